// ==== build.f ====
+incdir+.
dc2_pkg.sv
dc2_tag_ram.sv
dc2_init_sweep.sv
dc2_tag_arb.sv
dc2_tag_bank.sv
dc2_tag_top.sv
tb_dc2_tag.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the tag array testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_dc2_tag -o tb_dc2_tag
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

output=$(./obj_dir/tb_dc2_tag)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^Done: no errors$"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// ==== tb_dc2_tag.sv ====
`default_nettype none

`include "dc2_params.svh"

module tb_dc2_tag
  import dc2_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic                       port; // 0 lookup, 1 refill
    dc2_op_e                    op;
    logic [`DC2_LINE_WIDTH-1:0] line;
    logic                       excl;
    logic                       pair; // presented together with the next row
  } row_t;

  logic      clk = 1'b0;
  logic      rst;
  logic      lookup_valid;
  dc2_req_t  lookup_req;
  logic      grant_lookup;
  logic      refill_valid;
  dc2_req_t  refill_req;
  logic      grant_refill;
  logic      ready;
  logic      resp_valid;
  dc2_resp_t resp;

  row_t     rows [$];
  dc2_tag_t model [2][`DC2_SETS];
  int       seed = 32'hc83ee4b5;
  int       errors = 0;
  int       resp_count = 0;
  int       sweep_cycles = 0;
  logic     rows_built = 1'b0;
  logic     last_src = 1'b1; // refill counts as granted last after reset
  logic     pend_valid = 1'b0;
  logic     pend_src;
  dc2_req_t pend_req;

  dc2_tag_top DUT (
    .clk          (clk),
    .rst          (rst),
    .lookup_valid (lookup_valid),
    .lookup_req   (lookup_req),
    .grant_lookup (grant_lookup),
    .refill_valid (refill_valid),
    .refill_req   (refill_req),
    .grant_refill (grant_refill),
    .ready        (ready),
    .resp_valid   (resp_valid),
    .resp         (resp)
  );

  always #2 clk = ~clk;

  function automatic logic [`DC2_LINE_WIDTH-1:0] make_line(
    input logic [`DC2_TAG_WIDTH-1:0] tag, input logic [`DC2_INDEX_WIDTH-1:0] idx,
    input logic bank);
    return {tag, idx, bank};
  endfunction

  task automatic add_row(input logic port, input dc2_op_e op,
                         input logic [`DC2_LINE_WIDTH-1:0] line, input logic excl,
                         input logic pair);
    row_t r;
    r.port = port;
    r.op   = op;
    r.line = line;
    r.excl = excl;
    r.pair = pair;
    rows.push_back(r);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0.1f ns: %s is %h, expected %h", $realtime, name, actual, expected);
      errors++;
    end
  endtask

  // reference tag model, one step per response in arrival order
  function automatic dc2_resp_t model_step(input logic src, input dc2_req_t req);
    dc2_resp_t                   r;
    dc2_tag_t                    old;
    logic                        bank;
    logic [`DC2_INDEX_WIDTH-1:0] idx;
    logic [`DC2_TAG_WIDTH-1:0]   tag;
    logic                        hit;
    bank    = req.line[0];
    idx     = req.line[6:1];
    tag     = req.line[23:7];
    old     = model[bank][idx];
    hit     = old.valid && (old.tag == tag);
    r       = '0;
    r.src   = src;
    r.op    = req.op;
    r.hit   = hit;
    r.excl  = hit && old.excl;
    r.dirty = hit && old.dirty;
    case (req.op)
      op_write: begin
        if (hit) model[bank][idx].dirty = 1'b1;
      end
      op_fill: begin
        r.victim_valid   = old.valid;
        r.victim_dirty   = old.valid && old.dirty;
        r.victim_addr    = {old.tag, idx, bank};
        model[bank][idx] = '{valid: 1'b1, excl: req.excl, dirty: 1'b0, tag: tag};
      end
      op_evict: begin
        r.victim_valid = hit;
        r.victim_dirty = hit && old.dirty;
        r.victim_addr  = req.line;
        if (hit) model[bank][idx].valid = 1'b0;
      end
      default: ;
    endcase
    return r;
  endfunction

  task automatic compare_resp(input dc2_resp_t e);
    check_value("resp.src", 32'(resp.src), 32'(e.src));
    check_value("resp.op", 32'(resp.op), 32'(e.op));
    check_value("resp.hit", 32'(resp.hit), 32'(e.hit));
    check_value("resp.excl", 32'(resp.excl), 32'(e.excl));
    check_value("resp.dirty", 32'(resp.dirty), 32'(e.dirty));
    check_value("resp.victim_valid", 32'(resp.victim_valid), 32'(e.victim_valid));
    check_value("resp.victim_dirty", 32'(resp.victim_dirty), 32'(e.victim_dirty));
    if (e.victim_valid) begin
      check_value("resp.victim_addr", 32'(resp.victim_addr), 32'(e.victim_addr));
    end
  endtask

  task automatic drive_row(input row_t r);
    dc2_req_t q;
    q.op   = r.op;
    q.line = r.line;
    q.excl = r.excl;
    if (r.port) begin
      refill_req   = q;
      refill_valid = 1'b1;
    end else begin
      lookup_req   = q;
      lookup_valid = 1'b1;
    end
  endtask

  task automatic build_table();
    int k;
    for (k = 0; k < 16; k++) begin // untouched sets, both banks
      add_row(1'b0, op_read, make_line(17'($random(seed)), 6'(k * 4 + 2), k[0]), 1'b0, 1'b0);
    end
    add_row(1'b1, op_fill, make_line(17'h01234, 6'd5, 1'b0), 1'b1, 1'b0);
    add_row(1'b0, op_read, make_line(17'h01234, 6'd5, 1'b0), 1'b0, 1'b0); // back to back
    add_row(1'b0, op_read, make_line(17'h01235, 6'd5, 1'b0), 1'b0, 1'b0);
    add_row(1'b1, op_fill, make_line(17'h00abc, 6'd5, 1'b1), 1'b0, 1'b0);
    add_row(1'b0, op_read, make_line(17'h00abc, 6'd5, 1'b1), 1'b0, 1'b0);
    add_row(1'b0, op_read, make_line(17'h01234, 6'd5, 1'b1), 1'b0, 1'b0);
    add_row(1'b0, op_write, make_line(17'h01234, 6'd5, 1'b0), 1'b0, 1'b0);
    add_row(1'b0, op_read, make_line(17'h01234, 6'd5, 1'b0), 1'b0, 1'b0);
    add_row(1'b0, op_write, make_line(17'h1f00f, 6'd5, 1'b1), 1'b0, 1'b0); // write miss
    add_row(1'b0, op_read, make_line(17'h00abc, 6'd5, 1'b1), 1'b0, 1'b0);
    add_row(1'b1, op_fill, make_line(17'h00777, 6'd5, 1'b0), 1'b0, 1'b0); // dirty victim
    add_row(1'b1, op_evict, make_line(17'h00777, 6'd5, 1'b0), 1'b0, 1'b0);
    add_row(1'b0, op_read, make_line(17'h00777, 6'd5, 1'b0), 1'b0, 1'b0);
    add_row(1'b1, op_evict, make_line(17'h00777, 6'd5, 1'b0), 1'b0, 1'b0); // evict miss
    add_row(1'b1, op_fill, make_line(17'h15555, 6'd9, 1'b1), 1'b1, 1'b0);
    add_row(1'b0, op_write, make_line(17'h15555, 6'd9, 1'b1), 1'b0, 1'b0);
    add_row(1'b1, op_evict, make_line(17'h15555, 6'd9, 1'b1), 1'b0, 1'b0);
    add_row(1'b0, op_read, make_line(17'h15555, 6'd9, 1'b1), 1'b0, 1'b0);
    add_row(1'b1, op_fill, make_line(17'h00042, 6'd12, 1'b0), 1'b0, 1'b0);
    add_row(1'b1, op_fill, make_line(17'h00043, 6'd12, 1'b0), 1'b1, 1'b0);
    // both ports at once, different sets per pair
    add_row(1'b0, op_read, make_line(17'h00043, 6'd12, 1'b0), 1'b0, 1'b1);
    add_row(1'b1, op_fill, make_line(17'h02000, 6'd20, 1'b1), 1'b1, 1'b0);
    add_row(1'b0, op_read, make_line(17'h02000, 6'd20, 1'b1), 1'b0, 1'b1);
    add_row(1'b1, op_fill, make_line(17'h02001, 6'd21, 1'b0), 1'b0, 1'b0);
    add_row(1'b0, op_read, make_line(17'h02000, 6'd20, 1'b1), 1'b0, 1'b0); // lookup wins last
    add_row(1'b1, op_evict, make_line(17'h00043, 6'd12, 1'b0), 1'b0, 1'b1);
    add_row(1'b0, op_write, make_line(17'h02001, 6'd21, 1'b0), 1'b0, 1'b0);
    add_row(1'b0, op_read, make_line(17'h02001, 6'd21, 1'b0), 1'b0, 1'b1);
    add_row(1'b1, op_fill, make_line(17'h03000, 6'd30, 1'b1), 1'b0, 1'b0);
  endtask

  // ready, grants, response timing and response contents
  always @(negedge clk) begin : monitor
    dc2_resp_t exp_resp;
    logic      exp_ready;
    logic      exp_gl;
    logic      exp_gr;
    if (!rst) begin
      exp_ready = (sweep_cycles >= `DC2_SETS); // one sweep cycle per set
      check_value("ready", 32'(ready), 32'(exp_ready));
      exp_gl = exp_ready & lookup_valid & (~refill_valid | last_src);
      exp_gr = exp_ready & refill_valid & (~lookup_valid | ~last_src);
      check_value("grant_lookup", 32'(grant_lookup), 32'(exp_gl));
      check_value("grant_refill", 32'(grant_refill), 32'(exp_gr));
      if (pend_valid) begin
        exp_resp = model_step(pend_src, pend_req);
        if (!resp_valid) begin
          $display("Error at %0.1f ns: resp_valid missing in the cycle after a grant",
                   $realtime);
          errors++;
        end else begin
          compare_resp(exp_resp);
          resp_count++;
        end
      end else if (resp_valid) begin
        $display("Error at %0.1f ns: resp_valid without a grant one cycle earlier", $realtime);
        errors++;
      end
      pend_valid = grant_lookup | grant_refill;
      pend_src   = grant_refill;
      pend_req   = grant_refill ? refill_req : lookup_req;
      if (grant_lookup | grant_refill) last_src = grant_refill;
      if (sweep_cycles < `DC2_SETS) sweep_cycles++;
    end
  end

  initial begin
    wait (rows_built);
    #(4.0 * (64 + 10 * rows.size() + 20));
    $display("Error: watchdog expired before the test sequence finished");
    errors++;
    $display("errors: %0d, responses checked: %0d", errors, resp_count);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int   i;
    int   k;
    int   waited;
    logic got_lookup;
    logic got_refill;
    rst          = 1'b1;
    lookup_valid = 1'b1; // held through init, must not be granted
    refill_valid = 1'b1;
    lookup_req   = '{op: op_read, line: '0, excl: 1'b0};
    refill_req   = '{op: op_read, line: 24'h000003, excl: 1'b0};
    for (k = 0; k < 2 * `DC2_SETS; k++) begin
      model[k / `DC2_SETS][k % `DC2_SETS] = '0; // sweep leaves every set clear
    end
    build_table();
    rows_built = 1'b1;
    repeat (2) @(posedge clk);
    #0.5;
    rst = 1'b0;
    repeat (`DC2_SETS) @(negedge clk);
    @(posedge clk); // sweep ends on this edge
    #0.5;
    lookup_valid = 1'b0;
    refill_valid = 1'b0;
    @(posedge clk);
    #0.5;
    i = 0;
    while (i < rows.size()) begin
      drive_row(rows[i]);
      if (rows[i].pair && i + 1 < rows.size()) drive_row(rows[i + 1]);
      waited = 0;
      while (lookup_valid || refill_valid) begin
        @(negedge clk);
        got_lookup = grant_lookup;
        got_refill = grant_refill;
        waited++;
        @(posedge clk);
        #0.5;
        if (got_lookup) lookup_valid = 1'b0;
        if (got_refill) refill_valid = 1'b0;
        if ((lookup_valid || refill_valid) && waited >= 4) begin
          $display("Error at %0.1f ns: no grant within 4 cycles for row %0d", $realtime, i);
          errors++;
          lookup_valid = 1'b0;
          refill_valid = 1'b0;
        end
      end
      i += rows[i].pair ? 2 : 1;
    end
    repeat (3) @(negedge clk);
    check_value("response count", 32'(resp_count), 32'(rows.size()));
    $display("errors: %0d, responses checked: %0d", errors, resp_count);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dc2_tag_top.sv ====
`default_nettype none

`include "dc2_params.svh"

module dc2_tag_top
  import dc2_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      lookup_valid,
  input  dc2_req_t  lookup_req,
  output logic      grant_lookup,
  input  logic      refill_valid,
  input  dc2_req_t  refill_req,
  output logic      grant_refill,
  output logic      ready,
  output logic      resp_valid,
  output dc2_resp_t resp
);

  logic       issue;
  logic       issue_src;
  dc2_req_t   issue_req;
  logic       init;
  dc2_index_t init_index;

  logic       even_valid;
  logic       odd_valid;
  dc2_resp_t  even_resp;
  dc2_resp_t  odd_resp;

  dc2_init_sweep u_init (
    .clk        (clk),
    .rst        (rst),
    .init       (init),
    .init_index (init_index),
    .ready      (ready)
  );

  dc2_tag_arb u_arb (
    .clk          (clk),
    .rst          (rst),
    .ready        (ready),
    .lookup_valid (lookup_valid),
    .lookup_req   (lookup_req),
    .refill_valid (refill_valid),
    .refill_req   (refill_req),
    .grant_lookup (grant_lookup),
    .grant_refill (grant_refill),
    .issue        (issue),
    .issue_src    (issue_src),
    .issue_req    (issue_req)
  );

  dc2_tag_bank #(.BANK(1'b0)) u_even (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .issue_src  (issue_src),
    .issue_req  (issue_req),
    .init       (init),
    .init_index (init_index),
    .resp_valid (even_valid),
    .resp       (even_resp)
  );

  dc2_tag_bank #(.BANK(1'b1)) u_odd (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .issue_src  (issue_src),
    .issue_req  (issue_req),
    .init       (init),
    .init_index (init_index),
    .resp_valid (odd_valid),
    .resp       (odd_resp)
  );

  // one issue per cycle, so at most one bank answers
  assign resp_valid = even_valid | odd_valid;
  assign resp       = odd_valid ? odd_resp : even_resp;

endmodule

`default_nettype wire

// ==== dc2_tag_bank.sv ====
`default_nettype none

`include "dc2_params.svh"

// one direct-mapped bank; lookup in the cycle after issue
module dc2_tag_bank
  import dc2_pkg::*;
#(
  parameter bit BANK = 1'b0
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       issue,
  input  logic       issue_src,
  input  dc2_req_t   issue_req,
  input  logic       init,
  input  dc2_index_t init_index,
  output logic       resp_valid,
  output dc2_resp_t  resp
);

  logic       accept;
  logic       act_q;
  logic       src_q;
  dc2_req_t   req_q;

  dc2_index_t                issue_index;
  dc2_index_t                index_q;
  logic [`DC2_TAG_WIDTH-1:0] req_tag;

  dc2_tag_t   old_entry;
  dc2_tag_t   next_entry;
  dc2_tag_t   write_entry;
  dc2_index_t write_index;
  logic       write_en;
  logic       update;
  logic       hit;

  assign accept      = issue & (issue_req.line[`DC2_BANK_BIT] == BANK);
  assign issue_index = issue_req.line[`DC2_INDEX_LSB +: `DC2_INDEX_WIDTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      act_q <= 1'b0;
    end else begin
      act_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      src_q <= issue_src;
      req_q <= issue_req;
    end
  end

  dc2_tag_ram u_ram (
    .clk         (clk),
    .rst         (rst),
    .read_en     (accept),
    .read_index  (issue_index),
    .read_entry  (old_entry),
    .write_en    (write_en),
    .write_index (write_index),
    .write_entry (write_entry)
  );

  assign index_q = req_q.line[`DC2_INDEX_LSB +: `DC2_INDEX_WIDTH];
  assign req_tag = req_q.line[`DC2_TAG_LSB +: `DC2_TAG_WIDTH];
  assign hit     = old_entry.valid & (old_entry.tag == req_tag);

  always_comb begin
    next_entry = old_entry;
    update     = 1'b0;
    case (req_q.op)
      op_write: begin
        if (hit) begin
          next_entry.dirty = 1'b1;
          update           = 1'b1;
        end
      end
      op_fill: begin
        next_entry.valid = 1'b1;
        next_entry.excl  = req_q.excl;
        next_entry.dirty = 1'b0; // new line starts clean
        next_entry.tag   = req_tag;
        update           = 1'b1;
      end
      op_evict: begin
        if (hit) begin
          next_entry.valid = 1'b0;
          update           = 1'b1;
        end
      end
      default: begin
        update = 1'b0; // read leaves the set alone
      end
    endcase
  end

  // init sweep owns the write port while it runs
  assign write_en    = init | (act_q & update);
  assign write_index = init ? init_index : index_q;
  assign write_entry = init ? dc2_tag_t'('0) : next_entry;

  always_comb begin
    resp       = '0;
    resp.src   = src_q;
    resp.op    = req_q.op;
    resp.hit   = hit;
    resp.excl  = hit & old_entry.excl;
    resp.dirty = hit & old_entry.dirty;
    if (req_q.op == op_fill) begin
      resp.victim_valid = old_entry.valid;
      resp.victim_dirty = old_entry.valid & old_entry.dirty;
      if (old_entry.valid) begin
        resp.victim_addr = {old_entry.tag, index_q, BANK}; // displaced line
      end
    end else if (req_q.op == op_evict) begin
      resp.victim_valid = hit;
      resp.victim_dirty = hit & old_entry.dirty;
      if (hit) begin
        resp.victim_addr = req_q.line;
      end
    end
  end

  assign resp_valid = act_q;

endmodule

`default_nettype wire

// ==== dc2_tag_arb.sv ====
`default_nettype none

`include "dc2_params.svh"

// two-port round robin onto the shared tag array
module dc2_tag_arb
  import dc2_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     ready,
  input  logic     lookup_valid,
  input  dc2_req_t lookup_req,
  input  logic     refill_valid,
  input  dc2_req_t refill_req,
  output logic     grant_lookup,
  output logic     grant_refill,
  output logic     issue,
  output logic     issue_src,
  output dc2_req_t issue_req
);

  logic last_lookup_q; // 1 when lookup won last
  logic pick_lookup;
  logic pick_refill;

  // on a tie the port not served last goes first
  assign pick_lookup = lookup_valid & (~refill_valid | ~last_lookup_q);
  assign pick_refill = refill_valid & (~lookup_valid | last_lookup_q);

  assign grant_lookup = ready & pick_lookup;
  assign grant_refill = ready & pick_refill;

  assign issue     = grant_lookup | grant_refill;
  assign issue_src = grant_refill;
  assign issue_req = grant_refill ? refill_req : lookup_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_lookup_q <= 1'b0; // refill counts as last, lookup first
    end else if (issue) begin
      last_lookup_q <= grant_lookup;
    end
  end

endmodule

`default_nettype wire

// ==== dc2_init_sweep.sv ====
`default_nettype none

`include "dc2_params.svh"

module dc2_init_sweep
  import dc2_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  output logic       init,
  output dc2_index_t init_index,
  output logic       ready
);

  logic       busy_q;
  dc2_index_t count_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b1;
      count_q <= '0;
    end else if (busy_q) begin
      count_q <= count_q + 1'b1;
      if (count_q == dc2_index_t'(`DC2_SETS - 1)) begin
        busy_q <= 1'b0; // last set cleared
      end
    end
  end

  assign init       = busy_q;
  assign init_index = count_q;
  assign ready      = ~busy_q;

endmodule

`default_nettype wire

// ==== dc2_tag_ram.sv ====
`default_nettype none

`include "dc2_params.svh"

// write-first: read data comes from the held address, so a write on the
// capture edge is already visible when the data is used
module dc2_tag_ram
  import dc2_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       read_en,
  input  dc2_index_t read_index,
  output dc2_tag_t   read_entry,
  input  logic       write_en,
  input  dc2_index_t write_index,
  input  dc2_tag_t   write_entry
);

  dc2_tag_t   mem [`DC2_SETS];
  dc2_index_t read_index_q;

  assign read_entry = mem[read_index_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      read_index_q <= '0;
    end else if (read_en) begin
      read_index_q <= read_index;
    end
    if (write_en) begin
      mem[write_index] <= write_entry;
    end
  end

endmodule

`default_nettype wire

// ==== dc2_pkg.sv ====
`default_nettype none

`include "dc2_params.svh"

package dc2_pkg;

  typedef logic [`DC2_INDEX_WIDTH-1:0] dc2_index_t;

  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1, // store, dirties on hit
    op_fill  = 2'd2,
    op_evict = 2'd3
  } dc2_op_e;

  // one stored tag entry
  typedef struct packed {
    logic                      valid;
    logic                      excl;
    logic                      dirty;
    logic [`DC2_TAG_WIDTH-1:0] tag;
  } dc2_tag_t;

  typedef struct packed {
    dc2_op_e                    op;
    logic [`DC2_LINE_WIDTH-1:0] line;
    logic                       excl; // installed on fill only
  } dc2_req_t;

  typedef struct packed {
    logic                       src; // 0 lookup, 1 refill
    dc2_op_e                    op;
    logic                       hit;
    logic                       excl;
    logic                       dirty;
    logic                       victim_valid;
    logic                       victim_dirty;
    logic [`DC2_LINE_WIDTH-1:0] victim_addr;
  } dc2_resp_t;

endpackage

`default_nettype wire

// ==== dc2_params.svh ====
`ifndef DC2_PARAMS_SVH
`define DC2_PARAMS_SVH

// line address layout: tag | index | bank
`define DC2_LINE_WIDTH 24
`define DC2_INDEX_WIDTH 6
`define DC2_SETS 64
`define DC2_TAG_WIDTH 17

`define DC2_BANK_BIT 0 // even/odd split
`define DC2_INDEX_LSB 1 // index is line bits 6:1
`define DC2_TAG_LSB 7 // tag is line bits 23:7

`endif
